/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := axi_ice40_sram_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
+incdir+src
src/sram_pkg.sv
src/axi_sram_if.sv
src/sram_io_if.sv
src/axi_ice40_sram.sv
verification/sram_chip_model.sv
verification/axi_ice40_sram_tb.sv

/* src/axi_ice40_sram.sv */
`include "sram_params.svh"

module axi_ice40_sram (
  input  logic                        clk,
  input  logic                        i_rst,

  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  sram_pkg::axi_aw_t           i_aw,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  input  sram_pkg::axi_w_t            i_w,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  output sram_pkg::axi_b_t            o_b,

  input  logic                        i_arvalid,
  output logic                        o_arready,
  input  sram_pkg::axi_ar_t           i_ar,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output sram_pkg::axi_r_t            o_r,

  output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_addr,
  inout  wire  [`AXI_DATA_WIDTH-1:0]  io_sram_data,
  output logic                        o_sram_we_n,
  output logic                        o_sram_oe_n,
  output logic                        o_sram_ce_n
);
  import sram_pkg::*;

  logic          cmd_valid;
  logic          cmd_ready;
  sram_cmd_t     cmd;
  logic          rd_valid;
  logic          rd_ready;
  sram_rd_resp_t rd;

  axi_sram_if axi_sram_if_i (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_aw       (i_aw),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .i_w        (i_w),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_b        (o_b),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .i_ar       (i_ar),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_r        (o_r),
    .o_cmd_valid(cmd_valid),
    .i_cmd_ready(cmd_ready),
    .o_cmd      (cmd),
    .i_rd_valid (rd_valid),
    .o_rd_ready (rd_ready),
    .i_rd       (rd)
  );

  sram_io_if sram_io_if_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_cmd_valid (cmd_valid),
    .o_cmd_ready (cmd_ready),
    .i_cmd       (cmd),
    .o_rd_valid  (rd_valid),
    .i_rd_ready  (rd_ready),
    .o_rd        (rd),
    .o_sram_addr (o_sram_addr),
    .io_sram_data(io_sram_data),
    .o_sram_we_n (o_sram_we_n),
    .o_sram_oe_n (o_sram_oe_n),
    .o_sram_ce_n (o_sram_ce_n)
  );

endmodule

/* src/axi_sram_if.sv */
`include "sram_params.svh"

module axi_sram_if (
  input  logic                    clk,
  input  logic                    i_rst,

  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  sram_pkg::axi_aw_t       i_aw,

  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  sram_pkg::axi_w_t        i_w,

  output logic                    o_bvalid,
  input  logic                    i_bready,
  output sram_pkg::axi_b_t        o_b,

  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  sram_pkg::axi_ar_t       i_ar,

  output logic                    o_rvalid,
  input  logic                    i_rready,
  output sram_pkg::axi_r_t        o_r,

  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output sram_pkg::sram_cmd_t     o_cmd,

  input  logic                    i_rd_valid,
  output logic                    o_rd_ready,
  input  sram_pkg::sram_rd_resp_t i_rd
);
  import sram_pkg::*;

  axi_state_e                  state_q;
  logic [`SRAM_ADDR_WIDTH-1:0] addr_q;
  logic [7:0]                  beat_cnt_q;
  logic                        rd_issued_q;
  logic [`AXI_ID_WIDTH-1:0]    id_q;
  logic                        last_rd_q;

  logic                        aw_win;
  logic                        ar_win;
  logic                        cmd_fire;
  logic                        r_fire;

  // Round robin when both directions are pending
  assign aw_win = i_awvalid && (!i_arvalid || last_rd_q);
  assign ar_win = i_arvalid && (!i_awvalid || !last_rd_q);

  assign o_awready = (state_q == AXI_IDLE) && aw_win;
  assign o_arready = (state_q == AXI_IDLE) && ar_win;

  assign cmd_fire = o_cmd_valid && i_cmd_ready;
  assign r_fire   = o_rvalid && i_rready;

  // W beats pass straight through as commands
  assign o_wready = (state_q == AXI_WRITE) && i_cmd_ready;

  always_comb begin
    o_cmd.addr = addr_q;
    o_cmd.meta = id_q;
    if (state_q == AXI_WRITE) begin
      o_cmd_valid   = i_wvalid;
      o_cmd.last    = i_w.last;
      o_cmd.wr_en   = 1'b1;
      o_cmd.wr_data = i_w.data;
      o_cmd.wr_strb = i_w.strb;
    end else begin
      o_cmd_valid   = (state_q == AXI_READ) && !rd_issued_q;
      o_cmd.last    = (beat_cnt_q == 8'd0);
      o_cmd.wr_en   = 1'b0;
      o_cmd.wr_data = '0;
      o_cmd.wr_strb = '0;
    end
  end

  assign o_bvalid = (state_q == AXI_RESP);
  assign o_b.id   = id_q;
  assign o_b.resp = RESP_OKAY;

  // Read data returns tagged with the ID it was issued with
  assign o_rvalid   = (state_q == AXI_READ) && i_rd_valid;
  assign o_rd_ready = (state_q == AXI_READ) && i_rready;
  assign o_r.id     = i_rd.meta;
  assign o_r.data   = i_rd.data;
  assign o_r.resp   = RESP_OKAY;
  assign o_r.last   = i_rd.last;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q     <= AXI_IDLE;
      rd_issued_q <= 1'b0;
      last_rd_q   <= 1'b0;
    end else begin
      case (state_q)
        AXI_IDLE: begin
          if (o_awready) begin
            state_q   <= AXI_WRITE;
            last_rd_q <= 1'b0;
          end else if (o_arready) begin
            state_q     <= AXI_READ;
            last_rd_q   <= 1'b1;
            rd_issued_q <= 1'b0;
          end
        end
        AXI_WRITE: begin
          if (cmd_fire && i_w.last) begin
            state_q <= AXI_RESP;
          end
        end
        AXI_RESP: begin
          if (i_bready) begin
            state_q <= AXI_IDLE;
          end
        end
        AXI_READ: begin
          if (cmd_fire && beat_cnt_q == 8'd0) begin
            rd_issued_q <= 1'b1;
          end
          if (r_fire && i_rd.last) begin
            state_q <= AXI_IDLE;
          end
        end
        default: state_q <= AXI_IDLE;
      endcase
    end
  end

  // Word address drops the byte offset bit
  always_ff @(posedge clk) begin
    if (o_awready) begin
      id_q   <= i_aw.id;
      addr_q <= i_aw.addr[`AXI_ADDR_WIDTH-1 -: `SRAM_ADDR_WIDTH];
    end else if (o_arready) begin
      id_q       <= i_ar.id;
      addr_q     <= i_ar.addr[`AXI_ADDR_WIDTH-1 -: `SRAM_ADDR_WIDTH];
      beat_cnt_q <= i_ar.len;
    end else if (cmd_fire) begin
      addr_q <= addr_q + 1'b1;
      if (state_q == AXI_READ && beat_cnt_q != 8'd0) begin
        beat_cnt_q <= beat_cnt_q - 8'd1;
      end
    end
  end

endmodule

/* src/sram_io_if.sv */
`include "sram_params.svh"

module sram_io_if (
  input  logic                        clk,
  input  logic                        i_rst,

  input  logic                        i_cmd_valid,
  output logic                        o_cmd_ready,
  input  sram_pkg::sram_cmd_t         i_cmd,

  output logic                        o_rd_valid,
  input  logic                        i_rd_ready,
  output sram_pkg::sram_rd_resp_t     o_rd,

  output logic [`SRAM_ADDR_WIDTH-1:0] o_sram_addr,
  inout  wire  [`AXI_DATA_WIDTH-1:0]  io_sram_data,
  output logic                        o_sram_we_n,
  output logic                        o_sram_oe_n,
  output logic                        o_sram_ce_n
);
  import sram_pkg::*;

  io_state_e                   state_q;
  logic                        rmw_q;
  logic                        rd_valid_q;
  logic                        ce_n_q;
  logic                        we_n_q;
  logic                        oe_n_q;
  logic [`SRAM_ADDR_WIDTH-1:0] addr_q;
  logic [`SRAM_META_WIDTH-1:0] meta_q;
  logic                        last_q;
  logic [`AXI_DATA_WIDTH-1:0]  wr_data_q;
  logic [`AXI_STRB_WIDTH-1:0]  wr_strb_q;
  logic [`AXI_DATA_WIDTH-1:0]  rd_data_q;
  logic [`AXI_DATA_WIDTH-1:0]  merged;

  logic                        slot_free;
  logic                        cmd_fire;
  logic                        full_strb;
  logic                        rmw_merge;

  // Pins are idle in these states, so the next command can start
  assign slot_free = (state_q == IO_IDLE) || (state_q == IO_WR_REL) ||
                     (state_q == IO_RD_CAP && !rmw_q);
  assign rmw_merge = (state_q == IO_RD_CAP) && rmw_q;

  assign o_cmd_ready = slot_free && (!rd_valid_q || i_rd_ready);
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;
  assign full_strb   = &i_cmd.wr_strb;

  always_comb begin
    for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
      merged[8*i +: 8] = wr_strb_q[i] ? wr_data_q[8*i +: 8] : rd_data_q[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q    <= IO_IDLE;
      rmw_q      <= 1'b0;
      rd_valid_q <= 1'b0;
      ce_n_q     <= 1'b1;
      we_n_q     <= 1'b1;
      oe_n_q     <= 1'b1;
    end else begin
      if (rd_valid_q && i_rd_ready) begin
        rd_valid_q <= 1'b0;
      end
      case (state_q)
        IO_RD_OE: begin
          ce_n_q  <= 1'b1;
          oe_n_q  <= 1'b1;
          state_q <= IO_RD_CAP;
          // First half of a read-modify-write stays internal
          if (!rmw_q) begin
            rd_valid_q <= 1'b1;
          end
        end
        IO_WR_WE: begin
          ce_n_q  <= 1'b1;
          we_n_q  <= 1'b1;
          state_q <= IO_WR_REL;
        end
        default: begin
          if (rmw_merge) begin
            ce_n_q  <= 1'b0;
            we_n_q  <= 1'b0;
            state_q <= IO_WR_WE;
          end else if (cmd_fire) begin
            ce_n_q <= 1'b0;
            if (i_cmd.wr_en && full_strb) begin
              we_n_q  <= 1'b0;
              oe_n_q  <= 1'b1;
              rmw_q   <= 1'b0;
              state_q <= IO_WR_WE;
            end else begin
              we_n_q  <= 1'b1;
              oe_n_q  <= 1'b0;
              rmw_q   <= i_cmd.wr_en;
              state_q <= IO_RD_OE;
            end
          end else begin
            ce_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
            oe_n_q  <= 1'b1;
            state_q <= IO_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      addr_q    <= i_cmd.addr;
      meta_q    <= i_cmd.meta;
      last_q    <= i_cmd.last;
      wr_data_q <= i_cmd.wr_data;
      wr_strb_q <= i_cmd.wr_strb;
    end else if (rmw_merge) begin
      wr_data_q <= merged;
    end
    // Sampled at the end of the OE low cycle
    if (state_q == IO_RD_OE) begin
      rd_data_q <= io_sram_data;
    end
  end

  assign io_sram_data = (state_q == IO_WR_WE) ? wr_data_q : 'z;

  assign o_sram_addr = addr_q;
  assign o_sram_ce_n = ce_n_q;
  assign o_sram_we_n = we_n_q;
  assign o_sram_oe_n = oe_n_q;

  assign o_rd_valid = rd_valid_q;
  assign o_rd.meta  = meta_q;
  assign o_rd.last  = last_q;
  assign o_rd.data  = rd_data_q;

endmodule

/* src/sram_params.svh */
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// AXI subordinate side
`define AXI_ADDR_WIDTH 10
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4
`define AXI_STRB_WIDTH 2

// SRAM chip side is word addressed
`define SRAM_ADDR_WIDTH 9
`define SRAM_META_WIDTH `AXI_ID_WIDTH

`endif

/* src/sram_pkg.sv */
`include "sram_params.svh"

package sram_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic                       last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    axi_resp_e                resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_DATA_WIDTH-1:0] data;
    axi_resp_e                  resp;
    logic                       last;
  } axi_r_t;

  // One word access to the chip
  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_META_WIDTH-1:0] meta;
    logic                        last;
    logic                        wr_en;
    logic [`AXI_DATA_WIDTH-1:0]  wr_data;
    logic [`AXI_STRB_WIDTH-1:0]  wr_strb;
  } sram_cmd_t;

  typedef struct packed {
    logic [`SRAM_META_WIDTH-1:0] meta;
    logic                        last;
    logic [`AXI_DATA_WIDTH-1:0]  data;
  } sram_rd_resp_t;

  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_WRITE,
    AXI_RESP,
    AXI_READ
  } axi_state_e;

  typedef enum logic [2:0] {
    IO_IDLE,
    IO_RD_OE,
    IO_RD_CAP,
    IO_WR_WE,
    IO_WR_REL
  } io_state_e;

endpackage

/* verification/axi_ice40_sram_tb.sv */
`include "sram_params.svh"

module axi_ice40_sram_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import sram_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int SETTLE_NS   = 2;
  // Watchdog limit counts the beats of all tests
  localparam int TOTAL_BEATS = 61;

  logic clk = 1'b0;
  logic rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  axi_aw_t aw_in;
  axi_w_t  w_in;
  axi_b_t  b_out;
  axi_ar_t ar_in;
  axi_r_t  r_out;
  logic [`SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [`AXI_DATA_WIDTH-1:0]  sram_data;
  logic sram_we_n, sram_oe_n, sram_ce_n;

  logic [`AXI_DATA_WIDTH-1:0] ref_mem [0:(1<<`SRAM_ADDR_WIDTH)-1];
  logic [`AXI_DATA_WIDTH-1:0] last_rdata;
  integer seed;
  int errors;
  int checks;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_ice40_sram i_dut (
    .clk         (clk),
    .i_rst       (rst),
    .i_awvalid   (awvalid),
    .o_awready   (awready),
    .i_aw        (aw_in),
    .i_wvalid    (wvalid),
    .o_wready    (wready),
    .i_w         (w_in),
    .o_bvalid    (bvalid),
    .i_bready    (bready),
    .o_b         (b_out),
    .i_arvalid   (arvalid),
    .o_arready   (arready),
    .i_ar        (ar_in),
    .o_rvalid    (rvalid),
    .i_rready    (rready),
    .o_r         (r_out),
    .o_sram_addr (sram_addr),
    .io_sram_data(sram_data),
    .o_sram_we_n (sram_we_n),
    .o_sram_oe_n (sram_oe_n),
    .o_sram_ce_n (sram_ce_n)
  );

  sram_chip_model chip (
    .i_addr(sram_addr),
    .io_data(sram_data),
    .i_we_n(sram_we_n),
    .i_oe_n(sram_oe_n),
    .i_ce_n(sram_ce_n)
  );

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Same fill as the chip model
  function automatic logic [15:0] fill_word(input logic [8:0] a);
    return {7'h5A, a};
  endfunction

  task automatic axi_write_burst(input logic [3:0] tid, input logic [9:0] byte_addr,
                                 input int beats, input logic [15:0] first,
                                 input logic [15:0] step, input logic [1:0] strb);
    int beat;
    bit aw_fire;
    bit w_fire;
    bit b_fire;
    logic [8:0] waddr;
    beat = 0;
    waddr = byte_addr[9:1];
    @(negedge clk);
    aw_in = '{id: tid, addr: byte_addr, len: 8'(beats - 1), size: 3'd1, burst: 2'b01};
    awvalid = 1'b1;
    w_in = '{data: first, strb: strb, last: (beats == 1)};
    wvalid = 1'b1;
    while (beat < beats) begin
      #(SETTLE_NS);
      aw_fire = awvalid && awready;
      w_fire = wvalid && wready;
      @(negedge clk);
      if (aw_fire) awvalid = 1'b0;
      if (w_fire) begin
        // Strobed bytes replace the stored ones
        for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
          if (strb[i]) ref_mem[waddr + 9'(beat)][8*i +: 8] = w_in.data[8*i +: 8];
        end
        beat++;
        w_in.data = w_in.data + step;
        w_in.last = (beat == beats - 1);
        wvalid = (beat < beats);
      end
    end
    bready = 1'b1;
    do begin
      #(SETTLE_NS);
      b_fire = bvalid;
      if (b_fire) begin
        check_eq("b.id", b_out.id, tid);
        check_eq("b.resp", b_out.resp, RESP_OKAY);
      end
      @(negedge clk);
    end while (!b_fire);
    bready = 1'b0;
  endtask

  task automatic axi_read_burst(input logic [3:0] tid, input logic [9:0] byte_addr,
                                input int beats, input bit stall);
    int beat;
    bit ar_fire;
    logic [8:0] waddr;
    logic [31:0] coin;
    beat = 0;
    waddr = byte_addr[9:1];
    @(negedge clk);
    ar_in = '{id: tid, addr: byte_addr, len: 8'(beats - 1), size: 3'd1, burst: 2'b01};
    arvalid = 1'b1;
    rready = 1'b1;
    while (beat < beats) begin
      #(SETTLE_NS);
      ar_fire = arvalid && arready;
      if (rvalid && rready) begin
        check_eq("r.data", r_out.data, ref_mem[waddr + 9'(beat)]);
        check_eq("r.id", r_out.id, tid);
        check_eq("r.resp", r_out.resp, RESP_OKAY);
        check_eq("r.last", r_out.last, (beat == beats - 1));
        last_rdata = r_out.data;
        beat++;
      end
      @(negedge clk);
      if (ar_fire) arvalid = 1'b0;
      coin = $random(seed);
      rready = (beat < beats) && (!stall || coin[0]);
    end
    #(SETTLE_NS);
    check_eq("rvalid after rlast", rvalid, 1'b0);
  endtask

  task automatic check_idle_after_reset;
    #(SETTLE_NS);
    check_eq("awready", awready, 1'b0);
    check_eq("arready", arready, 1'b0);
    check_eq("wready", wready, 1'b0);
    check_eq("bvalid", bvalid, 1'b0);
    check_eq("rvalid", rvalid, 1'b0);
    check_eq("sram_ce_n", sram_ce_n, 1'b1);
    check_eq("sram_we_n", sram_we_n, 1'b1);
    check_eq("sram_oe_n", sram_oe_n, 1'b1);
  endtask

  task automatic single_word_write_read;
    axi_write_burst(4'h3, 10'h010, 1, 16'hBEEF, 16'h0000, 2'b11);
    axi_read_burst(4'h9, 10'h010, 1, 1'b0);
  endtask

  task automatic eight_beat_bursts;
    axi_write_burst(4'h1, 10'h040, 8, 16'h1357, 16'h2468, 2'b11);
    axi_read_burst(4'h2, 10'h040, 8, 1'b0);
  endtask

  task automatic partial_strobe_merge;
    axi_write_burst(4'h4, 10'h0A0, 1, 16'hAAAA, 16'h0000, 2'b11);
    axi_write_burst(4'h4, 10'h0A0, 1, 16'h1234, 16'h0000, 2'b01);
    axi_read_burst(4'h4, 10'h0A0, 1, 1'b0);
    check_eq("merged word", last_rdata, 16'hAA34);
  endtask

  task automatic read_with_backpressure;
    axi_write_burst(4'h7, 10'h200, 16, 16'h0F0F, 16'h1111, 2'b11);
    axi_read_burst(4'h8, 10'h200, 16, 1'b1);
  endtask

  // Read targets words that were never written
  task automatic simultaneous_aw_ar;
    fork
      axi_write_burst(4'h5, 10'h100, 4, 16'hC0DE, 16'h0101, 2'b11);
      axi_read_burst(4'h6, 10'h300, 4, 1'b0);
    join
  endtask

  initial begin
    seed = 72133;
    errors = 0;
    checks = 0;
    rst = 1'b1;
    awvalid = 1'b0;
    aw_in = '0;
    wvalid = 1'b0;
    w_in = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    ar_in = '0;
    rready = 1'b0;
    for (int a = 0; a < (1 << `SRAM_ADDR_WIDTH); a++) begin
      ref_mem[a] = fill_word(9'(a));
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_idle_after_reset();
    single_word_write_read();
    eight_beat_bursts();
    partial_strobe_merge();
    read_with_backpressure();
    simultaneous_aw_ar();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(TOTAL_BEATS * 20 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TOTAL_BEATS * 20);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* verification/sram_chip_model.sv */
`include "sram_params.svh"

module sram_chip_model (
  input  logic [`SRAM_ADDR_WIDTH-1:0] i_addr,
  inout  wire  [`AXI_DATA_WIDTH-1:0]  io_data,
  input  logic                        i_we_n,
  input  logic                        i_oe_n,
  input  logic                        i_ce_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW = `AXI_DATA_WIDTH;
  localparam int AW = `SRAM_ADDR_WIDTH;

  logic [DW-1:0]  mem [0:(1<<AW)-1];
  wire  [AW+DW:0] wr_now;
  wire  [AW+DW:0] wr_settled;

  // Fill word carries every address bit
  initial begin
    for (int a = 0; a < (1 << AW); a++) begin
      mem[a] = {7'h5A, AW'(a)};
    end
  end

  // Enable, address and data travel through one delay together
  assign wr_now = {!i_ce_n && !i_we_n, i_addr, io_data};
  assign #1 wr_settled = wr_now;

  always @(wr_settled) begin
    if (wr_settled[AW+DW]) begin
      mem[wr_settled[AW+DW-1:DW]] = wr_settled[DW-1:0];
    end
  end

  assign io_data = (!i_ce_n && !i_oe_n && i_we_n) ? mem[i_addr] : 'z;

endmodule
